// File: common/fdc_pkg.sv
// ====================
// shared constants and types of the two-drive fdc core
// drive facts (ready, tracks, sides, write protect) come from outside
// ====================
`default_nettype none

package fdc_pkg;

	localparam int NUM_DRIVES = 2;
	localparam int DRV_W = $clog2(NUM_DRIVES);   // drive index width
	localparam int CYL_W = 8;
	localparam int SRT_W = 4;
	localparam int CYCLES_PER_MS_DEF = 4000;    // clock cycles in one millisecond

	// ====================
	// main status register bits
	localparam int MSR_D0B = 0;
	localparam int MSR_D1B = 1;
	localparam int MSR_CB = 4;
	localparam int MSR_DIO = 6;
	localparam int MSR_RQM = 7;

	// command codes, low five bits, upper three must be zero
	localparam logic [4:0] CMD_SPECIFY = 5'd3;
	localparam logic [4:0] CMD_SENSE_DRIVE = 5'd4;
	localparam logic [4:0] CMD_RECALIBRATE = 5'd7;
	localparam logic [4:0] CMD_SENSE_INT = 5'd8;
	localparam logic [4:0] CMD_SEEK = 5'd15;

	// result bytes
	localparam logic [7:0] ST0_INVALID = 8'h80;   // also sense int with nothing pending
	localparam logic [7:0] ST0_SEEK_END = 8'h20;
	localparam logic [7:0] ST0_SEEK_ERR = 8'he8;  // abnormal end + seek end + not ready
	localparam logic [7:0] DATA_IDLE = 8'hff;     // data port read outside a result phase

	// ====================
	typedef struct packed {
		logic ready;
		logic write_protect;
		logic two_sided;
		logic [CYL_W-1:0] tracks;
	} drive_info_t;

	typedef struct packed {
		logic start;    // one cycle
		logic error;    // reject, interrupt without stepping
		logic [CYL_W-1:0] target;
	} seek_cmd_t;

	typedef struct packed {
		logic [CYL_W-1:0] pcn;
		logic seeking;
		logic int_pending;
		logic seek_ok;
	} seek_stat_t;

	// one-cycle pulses from the host port
	typedef struct packed {
		logic wr_data;
		logic rd_data;
		logic rd_status;
	} bus_evt_t;

endpackage

`default_nettype wire

// File: hw/host_port.sv
// ====================
// processor bus side, events appear one cycle after a strobe edge is sampled
// o_dout is loaded two cycles after nRD falls and holds until the next read
// ====================
`timescale 1ns/1ps
`default_nettype none

module host_port (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire                    i_n_rd,
	input  wire                    i_n_wr,
	input  wire                    i_a0,
	input  wire [7:0]              i_din,
	input  wire [7:0]              i_msr,
	input  wire [7:0]              i_data_byte,
	output fdc_pkg::bus_evt_t      o_evt,
	output logic [7:0]             o_wdata,
	output logic [7:0]             o_dout
);
	logic rd_q, rd_qq;   // sampled read condition, one cycle apart
	logic wr_q, wr_qq;
	logic a0_q;
	logic rd_start;
	logic wr_start;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_q <= 1'b0;
			rd_qq <= 1'b0;
			wr_q <= 1'b0;
			wr_qq <= 1'b0;
		end else begin
			rd_q <= ~i_n_rd & i_n_wr;
			rd_qq <= rd_q;
			wr_q <= ~i_n_wr & i_n_rd;
			wr_qq <= wr_q;
		end
	end

	always_ff @(posedge clk_sys) begin
		a0_q <= i_a0;
		if (~i_n_wr)
			o_wdata <= i_din;   // held stable by the host during the strobe
	end

	assign rd_start = rd_q & ~rd_qq;
	assign wr_start = wr_q & ~wr_qq;

	assign o_evt.wr_data = wr_start & a0_q;   // writes to A0=0 are dropped
	assign o_evt.rd_data = rd_start & a0_q;
	assign o_evt.rd_status = rd_start & ~a0_q;

	always_ff @(posedge clk_sys) begin
		if (reset)
			o_dout <= '0;
		else if (o_evt.rd_status)
			o_dout <= i_msr;
		else if (o_evt.rd_data)
			o_dout <= i_data_byte;
	end

	// a strobe must be released before the opposite one starts
	assert property (@(posedge clk_sys) disable iff (reset) rd_q |=> !wr_q);
	assert property (@(posedge clk_sys) disable iff (reset) wr_q |=> !rd_q);

endmodule

`default_nettype wire

// File: hw/command_sequencer.sv
// ====================
// command phase FSM for specify, seek, recalibrate and the two sense commands
// no execution phase, so RQM stays set and results follow the last byte
// ====================
`timescale 1ns/1ps
`default_nettype none

module command_sequencer (
	input  wire                           clk_sys,
	input  wire                           reset,
	input  wire fdc_pkg::bus_evt_t        i_evt,
	input  wire [7:0]                     i_wdata,
	input  wire fdc_pkg::drive_info_t     i_drive [fdc_pkg::NUM_DRIVES],
	input  wire fdc_pkg::seek_stat_t      i_seek_stat [fdc_pkg::NUM_DRIVES],
	output fdc_pkg::seek_cmd_t            o_seek_cmd [fdc_pkg::NUM_DRIVES],
	output logic [fdc_pkg::NUM_DRIVES-1:0] o_int_clear,
	output logic [fdc_pkg::SRT_W-1:0]     o_srt,
	output logic                          o_srt_load,
	output logic [7:0]                    o_msr,
	output logic [7:0]                    o_data_byte
);
	import fdc_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SPEC_SRT,
		ST_SPEC_HLT,
		ST_SEEK_DRV,
		ST_SEEK_CYL,
		ST_RECAL_DRV,
		ST_SENSE_DRV,
		ST_RESULT
	} state_t;

	state_t state;
	logic [DRV_W-1:0] cur_drv;    // drive of the seek being collected
	logic [DRV_W-1:0] wr_drv;
	logic [7:0] res_byte [2];
	logic res_idx;
	logic res_last;               // index of the final result byte
	logic int_found;
	logic [DRV_W-1:0] int_drv;
	logic [7:0] sense_st0;
	logic seek_bad;
	drive_info_t info;
	logic [7:0] st3;
	logic [2*NUM_DRIVES-1:0] cmd_pulses;

	assign wr_drv = i_wdata[DRV_W-1:0];

	// ====================
	// sense interrupt, lowest drive number served first
	always_comb begin
		int_found = 1'b0;
		int_drv = '0;
		for (int d = NUM_DRIVES - 1; d >= 0; d--) begin
			if (i_seek_stat[d].int_pending) begin
				int_found = 1'b1;
				int_drv = DRV_W'(d);
			end
		end
		sense_st0 = i_seek_stat[int_drv].seek_ok ? ST0_SEEK_END : ST0_SEEK_ERR;
		sense_st0 = sense_st0 | 8'(int_drv);
	end

	// ST3 of the drive named by the parameter byte
	always_comb begin
		info = i_drive[wr_drv];
		st3 = 8'h00;
		st3[6] = info.ready & info.write_protect;
		st3[5] = info.ready;
		st3[4] = info.ready & (i_seek_stat[wr_drv].pcn == '0);   // track 0
		st3[3] = info.ready & info.two_sided;
		st3[DRV_W-1:0] = wr_drv;
	end

	// cylinder 0 is always reachable
	assign seek_bad = (i_wdata != '0) &&
		(!i_drive[cur_drv].ready || i_wdata >= i_drive[cur_drv].tracks);

	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= ST_IDLE;
			res_idx <= 1'b0;
			o_int_clear <= '0;
			o_srt <= '0;
			o_srt_load <= 1'b0;
			for (int d = 0; d < NUM_DRIVES; d++) begin
				o_seek_cmd[d].start <= 1'b0;
				o_seek_cmd[d].error <= 1'b0;
			end
		end else begin
			o_int_clear <= '0;
			o_srt_load <= 1'b0;
			for (int d = 0; d < NUM_DRIVES; d++) begin
				o_seek_cmd[d].start <= 1'b0;
				o_seek_cmd[d].error <= 1'b0;
			end
			case (state)
				ST_IDLE: if (i_evt.wr_data) begin
					// invalid unless matched below
					res_idx <= 1'b0;
					res_last <= 1'b0;
					res_byte[0] <= ST0_INVALID;
					o_int_clear <= '1;
					state <= ST_RESULT;
					if (i_wdata[7:5] == 3'b000) begin
						case (i_wdata[4:0])
							CMD_SPECIFY: state <= ST_SPEC_SRT;
							CMD_SENSE_DRIVE: state <= ST_SENSE_DRV;
							CMD_RECALIBRATE: begin
								o_int_clear <= '0;
								state <= ST_RECAL_DRV;
							end
							CMD_SEEK: begin
								o_int_clear <= '0;
								state <= ST_SEEK_DRV;
							end
							CMD_SENSE_INT: begin
								o_int_clear <= '0;
								if (int_found) begin
									res_byte[0] <= sense_st0;
									res_byte[1] <= i_seek_stat[int_drv].pcn;
									res_last <= 1'b1;
									o_int_clear[int_drv] <= 1'b1;
								end
							end
							default: ;
						endcase
					end
				end
				ST_SPEC_SRT: if (i_evt.wr_data) begin
					o_srt <= i_wdata[7 -: SRT_W];
					o_srt_load <= 1'b1;
					state <= ST_SPEC_HLT;
				end
				ST_SPEC_HLT: if (i_evt.wr_data) begin
					state <= ST_IDLE;   // head load and dma mode not used
				end
				ST_SEEK_DRV: if (i_evt.wr_data) begin
					cur_drv <= wr_drv;
					state <= ST_SEEK_CYL;
				end
				ST_SEEK_CYL: if (i_evt.wr_data) begin
					o_seek_cmd[cur_drv].target <= i_wdata;
					if (seek_bad)
						o_seek_cmd[cur_drv].error <= 1'b1;
					else
						o_seek_cmd[cur_drv].start <= 1'b1;
					state <= ST_IDLE;
				end
				ST_RECAL_DRV: if (i_evt.wr_data) begin
					o_seek_cmd[wr_drv].target <= '0;
					o_seek_cmd[wr_drv].start <= 1'b1;
					state <= ST_IDLE;
				end
				ST_SENSE_DRV: if (i_evt.wr_data) begin
					res_byte[0] <= st3;
					state <= ST_RESULT;
				end
				ST_RESULT: if (i_evt.rd_data) begin
					if (res_idx == res_last)
						state <= ST_IDLE;
					else
						res_idx <= 1'b1;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// ====================
	always_comb begin
		o_msr = 8'h00;
		o_msr[MSR_RQM] = 1'b1;
		o_msr[MSR_DIO] = (state == ST_RESULT);
		o_msr[MSR_CB] = (state != ST_IDLE);
		o_msr[MSR_D0B] = i_seek_stat[0].seeking;
		o_msr[MSR_D1B] = i_seek_stat[1].seeking;
	end

	assign o_data_byte = (state == ST_RESULT) ? res_byte[res_idx] : DATA_IDLE;

	always_comb begin
		for (int d = 0; d < NUM_DRIVES; d++) begin
			cmd_pulses[2*d] = o_seek_cmd[d].start;
			cmd_pulses[2*d+1] = o_seek_cmd[d].error;
		end
	end

	// one seek request per cycle over all drives, never start with error
	assert property (@(posedge clk_sys) disable iff (reset) $onehot0(cmd_pulses));

endmodule

`default_nettype wire

// File: hw/step_timer.sv
// ====================
// one head-step tick every (16 - SRT) ms, SRT 0 gives 16 ms
// a load restarts the millisecond phase
// ====================
`timescale 1ns/1ps
`default_nettype none

module step_timer #(
	parameter int CYCLES_PER_MS = fdc_pkg::CYCLES_PER_MS_DEF
) (
	input  wire                        clk_sys,
	input  wire                        reset,
	input  wire [fdc_pkg::SRT_W-1:0]   i_srt,
	input  wire                        i_srt_load,
	output logic                       o_step_tick
);
	import fdc_pkg::*;

	localparam int PRE_W = $clog2(CYCLES_PER_MS + 1);
	localparam logic [PRE_W-1:0] PRE_LOAD = PRE_W'(CYCLES_PER_MS - 1);

	logic [PRE_W-1:0] pre_cnt;   // millisecond prescaler
	logic [SRT_W-1:0] srt_cnt;   // counts up to wrap, then reloads
	logic ms_tick;

	assign ms_tick = (pre_cnt == '0);

	always_ff @(posedge clk_sys) begin
		o_step_tick <= 1'b0;
		if (reset) begin
			pre_cnt <= PRE_LOAD;
			srt_cnt <= '0;
		end else if (i_srt_load) begin
			pre_cnt <= PRE_LOAD;
			srt_cnt <= i_srt;
		end else if (ms_tick) begin
			pre_cnt <= PRE_LOAD;
			if (&srt_cnt) begin
				srt_cnt <= i_srt;
				o_step_tick <= 1'b1;
			end else
				srt_cnt <= srt_cnt + 1'b1;
		end else
			pre_cnt <= pre_cnt - 1'b1;
	end

endmodule

`default_nettype wire

// File: hw/seek_engine.sv
// ====================
// present cylinder of one drive, one step per tick toward the target
// a new start drops any pending interrupt of this drive
// ====================
`timescale 1ns/1ps
`default_nettype none

module seek_engine (
	input  wire                      clk_sys,
	input  wire                      reset,
	input  wire fdc_pkg::seek_cmd_t  i_cmd,
	input  wire                      i_step_tick,
	input  wire                      i_ready,
	input  wire                      i_int_clear,
	output fdc_pkg::seek_stat_t      o_stat
);
	import fdc_pkg::*;

	logic [CYL_W-1:0] target;
	logic [CYL_W-1:0] pcn;
	logic seeking;
	logic int_pending;
	logic seek_ok;

	always_ff @(posedge clk_sys) begin
		if (i_cmd.start)
			target <= i_cmd.target;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pcn <= '0;
			seeking <= 1'b0;
			int_pending <= 1'b0;
			seek_ok <= 1'b0;
		end else if (i_cmd.start) begin
			seeking <= 1'b1;
			int_pending <= 1'b0;
			seek_ok <= 1'b0;
		end else if (i_cmd.error) begin
			seeking <= 1'b0;     // rejected, head stays put
			int_pending <= 1'b1;
			seek_ok <= 1'b0;
		end else begin
			if (i_int_clear)
				int_pending <= 1'b0;
			if (seeking) begin
				if (pcn == target) begin
					seeking <= 1'b0;
					int_pending <= 1'b1;   // arrival wins over a clear
					seek_ok <= i_ready;
				end else if (i_step_tick) begin
					if (pcn < target)
						pcn <= pcn + 1'b1;
					else
						pcn <= pcn - 1'b1;
				end
			end
		end
	end

	assign o_stat.pcn = pcn;
	assign o_stat.seeking = seeking;
	assign o_stat.int_pending = int_pending;
	assign o_stat.seek_ok = seek_ok;

	// head moves at most one cylinder per clock
	assert property (@(posedge clk_sys) disable iff (reset)
		pcn != $past(pcn) |-> pcn == $past(pcn) + 1'b1 || pcn == $past(pcn) - 1'b1);

endmodule

`default_nettype wire

// File: hw/fdc_top.sv
// ====================
// two-drive fdc core, host side only, runs on every clk_sys cycle
// host must hold nRD/nWR at least 3 cycles with A0 and data stable
// ====================
`timescale 1ns/1ps
`default_nettype none

module fdc_top #(
	parameter int CYCLES_PER_MS = fdc_pkg::CYCLES_PER_MS_DEF
) (
	input  wire                       clk_sys,
	input  wire                       reset,
	input  wire                       i_n_rd,
	input  wire                       i_n_wr,
	input  wire                       i_a0,
	input  wire [7:0]                 i_din,
	input  wire fdc_pkg::drive_info_t i_drive [fdc_pkg::NUM_DRIVES],
	output logic [7:0]                o_dout
);
	import fdc_pkg::*;

	bus_evt_t evt;
	logic [7:0] wdata;
	logic [7:0] msr;
	logic [7:0] data_byte;
	seek_cmd_t seek_cmd [NUM_DRIVES];
	seek_stat_t seek_stat [NUM_DRIVES];
	logic [NUM_DRIVES-1:0] int_clear;
	logic [SRT_W-1:0] srt;
	logic srt_load;
	logic step_tick;    // shared by both drives

	host_port u_host_port (
		.clk_sys(clk_sys), .reset(reset),
		.i_n_rd(i_n_rd), .i_n_wr(i_n_wr), .i_a0(i_a0),
		.i_din(i_din), .i_msr(msr), .i_data_byte(data_byte),
		.o_evt(evt), .o_wdata(wdata), .o_dout(o_dout)
	);

	command_sequencer u_command_sequencer (
		.clk_sys(clk_sys), .reset(reset),
		.i_evt(evt), .i_wdata(wdata), .i_drive(i_drive),
		.i_seek_stat(seek_stat), .o_seek_cmd(seek_cmd), .o_int_clear(int_clear),
		.o_srt(srt), .o_srt_load(srt_load), .o_msr(msr), .o_data_byte(data_byte)
	);

	step_timer #(.CYCLES_PER_MS(CYCLES_PER_MS)) u_step_timer (
		.clk_sys(clk_sys), .reset(reset),
		.i_srt(srt), .i_srt_load(srt_load), .o_step_tick(step_tick)
	);

	for (genvar d = 0; d < NUM_DRIVES; d++) begin : g_drive
		seek_engine u_seek_engine (
			.clk_sys(clk_sys), .reset(reset),
			.i_cmd(seek_cmd[d]), .i_step_tick(step_tick), .i_ready(i_drive[d].ready),
			.i_int_clear(int_clear[d]), .o_stat(seek_stat[d])
		);
	end

endmodule

`default_nettype wire

// File: testbench/tb_fdc.sv
// ====================
// drives the fdc core through its bus strobes, one byte per 8-cycle access
// CYCLES_PER_MS is 4 so that seeks finish in a few hundred cycles
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_fdc;
	import fdc_pkg::*;

	localparam int CPMS = 4;
	localparam int TRACKS0 = 40;
	localparam int TRACKS1 = 30;
	localparam logic [3:0] SRT = 4'd13;
	localparam int STEP_CYCLES = (16 - SRT) * CPMS;
	// slowest possible step rate, full track count, three seeks
	localparam int SEEK_MAX = TRACKS0 * 16 * CPMS;
	localparam int CYCLE_LIMIT = 2 * (3 * SEEK_MAX) + 2000;

	logic clk_sys = 1'b0;
	logic reset;
	logic n_rd;
	logic n_wr;
	logic a0;
	logic [7:0] din;
	logic [7:0] o_dout;
	drive_info_t drive [NUM_DRIVES];
	logic [31:0] lfsr_state;
	int cycle = 0;

	fdc_top #(.CYCLES_PER_MS(CPMS)) i_fdc_top (
		.clk_sys(clk_sys), .reset(reset),
		.i_n_rd(n_rd), .i_n_wr(n_wr), .i_a0(a0), .i_din(din),
		.i_drive(drive), .o_dout(o_dout)
	);

	always #4 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT)
			abort_run($sformatf("timeout, test still running after %0d cycles", cycle));
	end

	// ====================
	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic compare_byte(input string name, input logic [7:0] got,
			input logic [7:0] exp);
		assert (got === exp)
		else abort_run($sformatf("mismatch at %0t: %s got %h expected %h",
			$time, name, got, exp));
	endtask

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_bits(input int n);
		logic fb;
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			value = {value[30:0], fb};
		end
		return value;
	endfunction

	// ====================
	// strobe low 4 cycles, high 4 cycles
	task automatic write_byte(input logic [7:0] data);
		n_wr <= 1'b0;
		a0 <= 1'b1;
		din <= data;
		repeat (4) @(posedge clk_sys);
		n_wr <= 1'b1;
		repeat (4) @(posedge clk_sys);
	endtask

	task automatic read_byte(input logic addr, output logic [7:0] data);
		n_rd <= 1'b0;
		a0 <= addr;
		repeat (3) @(posedge clk_sys);
		data = o_dout;   // loaded 2 cycles after nRD fell
		@(posedge clk_sys);
		n_rd <= 1'b1;
		repeat (4) @(posedge clk_sys);
	endtask

	task automatic expect_msr(input logic [7:0] exp);
		logic [7:0] got;
		read_byte(1'b0, got);
		compare_byte("msr", got, exp);
	endtask

	task automatic expect_result(input string name, input logic [7:0] exp);
		logic [7:0] got;
		read_byte(1'b1, got);
		compare_byte(name, got, exp);
	endtask

	// poll until the drive busy bit drops
	task automatic wait_drive_idle(input int drv);
		logic [7:0] msr;
		msr = 8'hff;
		while (msr[drv] !== 1'b0) begin
			read_byte(1'b0, msr);
			compare_byte("msr without drive bits", msr & 8'hfc, 8'h80);
		end
	endtask

	// ST3: wp, ready, track 0, two sided, drive number
	function automatic logic [7:0] expected_st3(input int drv, input logic [7:0] pcn);
		logic [7:0] v;
		v = 8'h00;
		if (drive[drv].ready) begin
			v[6] = drive[drv].write_protect;
			v[5] = 1'b1;
			v[4] = (pcn == 8'h00);
			v[3] = drive[drv].two_sided;
		end
		v[0] = drv[0];
		return v;
	endfunction

	task automatic sense_drive(input int drv, input logic [7:0] pcn);
		write_byte(8'h04);
		write_byte(8'(drv));
		expect_msr(8'hd0);
		expect_result("st3", expected_st3(drv, pcn));
		expect_msr(8'h80);
	endtask

	// ====================
	assert property (@(posedge clk_sys) disable iff (reset)
		n_rd && $past(n_rd) && $past(n_rd, 2) |-> $stable(o_dout))
	else abort_run("o_dout changed while no read was in progress");

	assert property (@(posedge clk_sys) reset |=> o_dout == 8'h00)
	else abort_run($sformatf("mismatch at %0t: o_dout got %h expected 00", $time, o_dout));

	initial begin
		logic [31:0] rnd;
		logic [7:0] target;
		logic [7:0] beyond;
		int t_start;
		int elapsed;
		reset = 1'b1;
		n_rd = 1'b1;
		n_wr = 1'b1;
		a0 = 1'b0;
		din = 8'h00;
		lfsr_state = 32'h24b6;
		drive[0].ready = 1'b1;
		drive[0].write_protect = 1'b0;
		drive[0].two_sided = 1'b1;
		drive[0].tracks = 8'(TRACKS0);
		drive[1].ready = 1'b1;
		drive[1].write_protect = 1'b1;
		drive[1].two_sided = 1'b0;
		drive[1].tracks = 8'(TRACKS1);
		repeat (8) @(posedge clk_sys);
		reset <= 1'b0;
		@(posedge clk_sys);

		expect_msr(8'h80);

		// invalid command
		write_byte(8'h1f);
		expect_msr(8'hd0);
		expect_result("st0 invalid", 8'h80);
		expect_msr(8'h80);

		write_byte(8'h03);   // specify
		write_byte({SRT, 4'h0});
		write_byte(8'h02);
		expect_msr(8'h80);

		// at least two steps so the busy bit is seen
		rnd = lfsr_bits(8);
		target = 8'(2 + int'(rnd[7:0]) % (TRACKS0 - 2));
		write_byte(8'h0f);
		write_byte(8'h00);
		t_start = cycle;
		write_byte(target);
		expect_msr(8'h81);
		wait_drive_idle(0);
		elapsed = cycle - t_start;
		assert (elapsed >= (int'(target) - 1) * STEP_CYCLES)
		else abort_run($sformatf("seek of %0d cylinders ended after %0d cycles, minimum %0d",
			target, elapsed, (int'(target) - 1) * STEP_CYCLES));

		write_byte(8'h08);   // sense interrupt
		expect_msr(8'hd0);
		expect_result("st0 seek end", 8'h20);
		expect_result("pcn", target);
		expect_msr(8'h80);
		write_byte(8'h08);
		expect_result("st0 nothing pending", 8'h80);

		// drive 1 past its last track
		rnd = lfsr_bits(3);
		beyond = 8'(TRACKS1 + int'(rnd[2:0]));
		write_byte(8'h0f);
		write_byte(8'h01);
		write_byte(beyond);
		expect_msr(8'h80);
		write_byte(8'h08);
		expect_result("st0 seek error", 8'he9);
		expect_result("pcn drive 1", 8'h00);
		expect_msr(8'h80);

		sense_drive(0, target);
		sense_drive(1, 8'h00);

		write_byte(8'h07);   // recalibrate drive 0
		write_byte(8'h00);
		wait_drive_idle(0);
		sense_drive(0, 8'h00);

		// sense drive status dropped the recalibrate interrupt
		write_byte(8'h08);
		expect_result("st0 after sense drive", 8'h80);
		expect_msr(8'h80);

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
common/fdc_pkg.sv
hw/host_port.sv
hw/command_sequencer.sv
hw/step_timer.sv
hw/seek_engine.sv
hw/fdc_top.sv
testbench/tb_fdc.sv

// File: Makefile
TOP = tb_fdc

all: run

run: obj_dir/$(TOP)
	./obj_dir/$(TOP)

obj_dir/$(TOP): list.f $(shell cat list.f)
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o $(TOP)

lint:
	verilator --lint-only --timing -Wall -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
